//--- verilog/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_DATA_WIDTH 32     // Data word
`define CORE_REG_ADDR_WIDTH 4  // Register index
`define CORE_NUM_REGS 16
`define CORE_FLAGS_WIDTH 4     // NZCV
`define CORE_IMM_WIDTH 12      // Zero-extended immediate
`define CORE_SHAMT_WIDTH 5

// Instruction field positions
`define CORE_I_BIT 25          // Immediate select
`define CORE_OPC_MSB 24
`define CORE_OPC_LSB 21
`define CORE_S_BIT 20          // Set flags
`define CORE_RN_MSB 19
`define CORE_RN_LSB 16
`define CORE_RD_MSB 15
`define CORE_RD_LSB 12
`define CORE_SHAMT_MSB 11
`define CORE_SHAMT_LSB 7
`define CORE_SHTYPE_MSB 6
`define CORE_SHTYPE_LSB 5
`define CORE_RM_MSB 3
`define CORE_RM_LSB 0

`endif

//--- verilog/isaPkg.sv
`include "core_params.svh"

package isaPkg;

  // Data-processing opcodes, ARM encoding
  typedef enum logic [`CORE_OPC_MSB-`CORE_OPC_LSB:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opAdd = 4'd4,
    opAdc = 4'd5,
    opCmp = 4'd10,  // Flags only, no write
    opOrr = 4'd12,
    opMov = 4'd13
  } opcodeT;        // Other codes act as no-op

  // Shift applied to the register operand
  typedef enum logic [`CORE_SHTYPE_MSB-`CORE_SHTYPE_LSB:0] {
    shLsl = 2'd0,
    shLsr = 2'd1,
    shAsr = 2'd2,
    shRor = 2'd3
  } shiftT;

  // Bit positions inside the NZCV word
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

endpackage

//--- verilog/pipePkg.sv
`include "core_params.svh"

package pipePkg;

  typedef logic [`CORE_DATA_WIDTH-1:0] wordT;

  typedef logic [`CORE_REG_ADDR_WIDTH-1:0] regAddrT;

  // Operand source in execute
  // Order matches the classic three-way bypass mux
  typedef enum logic [1:0] {
    fwdReg = 2'd0,  // Value read in decode
    fwdW   = 2'd1,  // Writeback result
    fwdM   = 2'd2   // Memory stage result, newest
  } fwdSelT;

endpackage

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

`include "core_params.svh"

module instrDecoder (
  input  pipePkg::wordT                instr,
  output isaPkg::opcodeT               opcode,
  output logic                         setFlags,  // Effective flag update
  output logic                         useImm,
  output logic                         regWrite,  // Rd is written
  output pipePkg::regAddrT             rn,
  output pipePkg::regAddrT             rm,
  output pipePkg::regAddrT             rd,
  output pipePkg::wordT                imm,
  output logic [`CORE_SHAMT_WIDTH-1:0] shamt,
  output isaPkg::shiftT                shiftType
);

  logic sBit;
  logic isCmp;
  logic known;  // One of the eight supported opcodes

  // Plain field cuts
  assign opcode    = isaPkg::opcodeT'(instr[`CORE_OPC_MSB:`CORE_OPC_LSB]);
  assign sBit      = instr[`CORE_S_BIT];
  assign useImm    = instr[`CORE_I_BIT];
  assign rn        = instr[`CORE_RN_MSB:`CORE_RN_LSB];
  assign rd        = instr[`CORE_RD_MSB:`CORE_RD_LSB];
  assign rm        = instr[`CORE_RM_MSB:`CORE_RM_LSB];
  assign shamt     = instr[`CORE_SHAMT_MSB:`CORE_SHAMT_LSB];
  assign shiftType = isaPkg::shiftT'(instr[`CORE_SHTYPE_MSB:`CORE_SHTYPE_LSB]);

  // Immediate is zero-extended, no rotation
  assign imm = {{(`CORE_DATA_WIDTH - `CORE_IMM_WIDTH){1'b0}}, instr[`CORE_IMM_WIDTH-1:0]};

  // Writing opcodes; CMP and unknown codes fall to default
  always_comb begin
    case (opcode)
      isaPkg::opAnd, isaPkg::opEor, isaPkg::opSub, isaPkg::opAdd,
      isaPkg::opAdc, isaPkg::opOrr, isaPkg::opMov: regWrite = 1'b1;
      default:                                     regWrite = 1'b0;
    endcase
  end

  assign isCmp = (opcode == isaPkg::opCmp);
  assign known = regWrite | isCmp;

  // CMP always sets flags, the rest only with S
  assign setFlags = known & (sBit | isCmp);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

`include "core_params.svh"

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  pipePkg::regAddrT ra1,
  input  pipePkg::regAddrT ra2,
  input  logic             we,
  input  pipePkg::regAddrT wa,
  input  pipePkg::wordT    wd,
  output pipePkg::wordT    rd1,
  output pipePkg::wordT    rd2
);

  pipePkg::wordT regs [`CORE_NUM_REGS];

  logic hit1;  // Port 1 reads the register being written
  logic hit2;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Write-through so decode sees the writeback of the same cycle
  assign hit1 = we && (wa == ra1);
  assign hit2 = we && (wa == ra2);

  assign rd1 = hit1 ? wd : regs[ra1];
  assign rd2 = hit2 ? wd : regs[ra2];

endmodule

//--- verilog/barrelShifter.sv
`timescale 1ns/1ps

`include "core_params.svh"

module barrelShifter (
  input  pipePkg::wordT                value,
  input  logic [`CORE_SHAMT_WIDTH-1:0] shamt,
  input  isaPkg::shiftT                shiftType,
  output pipePkg::wordT                shifted
);

  logic [2*`CORE_DATA_WIDTH-1:0] doubled;  // Value beside itself for rotation
  logic [2*`CORE_DATA_WIDTH-1:0] rotated;

  assign doubled = {value, value};
  assign rotated = doubled >> shamt;

  // Amount 0 leaves the operand as is for every type
  always_comb begin
    case (shiftType)
      isaPkg::shLsl: shifted = value << shamt;
      isaPkg::shLsr: shifted = value >> shamt;
      isaPkg::shAsr: shifted = $signed(value) >>> shamt;   // Sign bit fills in
      default:       shifted = rotated[`CORE_DATA_WIDTH-1:0];  // ROR
    endcase
  end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

`include "core_params.svh"

module alu (
  input  pipePkg::wordT                a,
  input  pipePkg::wordT                b,
  input  isaPkg::opcodeT               opcode,
  input  logic                         carryIn,
  input  logic                         overflowIn,  // Current V, kept by logical ops
  output pipePkg::wordT                result,
  output logic [`CORE_FLAGS_WIDTH-1:0] newFlags
);

  logic                       isSub;  // SUB or CMP
  logic                       isArith;
  pipePkg::wordT              bOp;    // b, inverted when subtracting
  logic                       cin;
  logic [`CORE_DATA_WIDTH:0]  sum;    // Carry in the top bit

  assign isSub = (opcode == isaPkg::opSub) || (opcode == isaPkg::opCmp);

  always_comb begin
    case (opcode)
      isaPkg::opSub, isaPkg::opAdd,
      isaPkg::opAdc, isaPkg::opCmp: isArith = 1'b1;
      default:                      isArith = 1'b0;
    endcase
  end

  // a - b done as a + ~b + 1, so carry out is the inverted borrow
  assign bOp = isSub ? ~b : b;
  assign cin = isSub ? 1'b1 : ((opcode == isaPkg::opAdc) ? carryIn : 1'b0);
  assign sum = {1'b0, a} + {1'b0, bOp} + {{`CORE_DATA_WIDTH{1'b0}}, cin};

  always_comb begin
    case (opcode)
      isaPkg::opAnd: result = a & b;
      isaPkg::opEor: result = a ^ b;
      isaPkg::opOrr: result = a | b;
      isaPkg::opMov: result = b;
      isaPkg::opSub, isaPkg::opAdd,
      isaPkg::opAdc, isaPkg::opCmp: result = sum[`CORE_DATA_WIDTH-1:0];
      default:       result = '0;  // No-op
    endcase
  end

  assign newFlags[isaPkg::flagN] = result[`CORE_DATA_WIDTH-1];
  assign newFlags[isaPkg::flagZ] = (result == '0);
  assign newFlags[isaPkg::flagC] = isArith ? sum[`CORE_DATA_WIDTH] : carryIn;

  // Overflow when both inputs share a sign the sum does not
  assign newFlags[isaPkg::flagV] = isArith ?
      ((a[`CORE_DATA_WIDTH-1] == bOp[`CORE_DATA_WIDTH-1]) &&
       (sum[`CORE_DATA_WIDTH-1] != a[`CORE_DATA_WIDTH-1])) :
      overflowIn;

endmodule

//--- verilog/forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit (
  input  pipePkg::regAddrT rnE,
  input  pipePkg::regAddrT rmE,
  input  pipePkg::regAddrT rdM,
  input  logic             writeM,  // Valid and writing
  input  pipePkg::regAddrT rdW,
  input  logic             writeW,
  output pipePkg::fwdSelT  fwdA,
  output pipePkg::fwdSelT  fwdB
);

  logic matchAM;  // Rn hits M
  logic matchAW;
  logic matchBM;  // Rm hits M
  logic matchBW;

  assign matchAM = writeM && (rdM == rnE);
  assign matchAW = writeW && (rdW == rnE);
  assign matchBM = writeM && (rdM == rmE);
  assign matchBW = writeW && (rdW == rmE);

  // M is younger than W, so it wins a double hit
  always_comb begin
    if (matchAM)
      fwdA = pipePkg::fwdM;
    else if (matchAW)
      fwdA = pipePkg::fwdW;
    else
      fwdA = pipePkg::fwdReg;  // Register file, write-through included
  end

  always_comb begin
    if (matchBM)
      fwdB = pipePkg::fwdM;
    else if (matchBW)
      fwdB = pipePkg::fwdW;
    else
      fwdB = pipePkg::fwdReg;
  end

  // Older producers are already in the register file

endmodule

//--- verilog/pipeCore.sv
`timescale 1ns/1ps

`include "core_params.svh"

module pipeCore (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         instrValid,  // One-cycle strobe per instruction
  input  pipePkg::wordT                instr,
  output logic                         wbValid,
  output pipePkg::regAddrT             wbReg,
  output pipePkg::wordT                wbData,
  output logic [`CORE_FLAGS_WIDTH-1:0] flags       // Architectural NZCV
);

  // Decode stage
  pipePkg::wordT                instrD;
  logic                         validD;
  isaPkg::opcodeT               opcodeD;
  logic                         setFlagsD, useImmD, regWriteD;
  pipePkg::regAddrT             rnD, rmD, rdD;
  pipePkg::wordT                immD, rd1D, rd2D;
  logic [`CORE_SHAMT_WIDTH-1:0] shamtD;
  isaPkg::shiftT                shiftTypeD;

  // Execute stage
  logic                         validE, setFlagsE, regWriteE;
  isaPkg::opcodeT               opcodeE;
  logic                         useImmE;
  pipePkg::regAddrT             rnE, rmE, rdE;
  pipePkg::wordT                immE, rd1E, rd2E;
  logic [`CORE_SHAMT_WIDTH-1:0] shamtE;
  isaPkg::shiftT                shiftTypeE;
  pipePkg::fwdSelT              fwdA, fwdB;
  pipePkg::wordT                srcA, srcRm, shiftedRm, srcB, resultE;
  logic [`CORE_FLAGS_WIDTH-1:0] newFlags;

  // M and W stages, write bits carry the valid
  logic                         writeM, writeW;
  pipePkg::regAddrT             rdM, rdW;
  pipePkg::wordT                resultM, resultW;

  // Bypass select, same for both operands
  function automatic pipePkg::wordT fwdMux(input pipePkg::fwdSelT sel,
                                           input pipePkg::wordT regVal,
                                           input pipePkg::wordT wVal,
                                           input pipePkg::wordT mVal);
    case (sel)
      pipePkg::fwdM: return mVal;
      pipePkg::fwdW: return wVal;
      default:       return regVal;
    endcase
  endfunction

  // Valid bits and write enables
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validD    <= 1'b0;
      validE    <= 1'b0;
      setFlagsE <= 1'b0;
      regWriteE <= 1'b0;
      writeM    <= 1'b0;
      writeW    <= 1'b0;
    end else begin
      validD    <= instrValid;
      validE    <= validD;               // Bubble when D was empty
      setFlagsE <= validD & setFlagsD;
      regWriteE <= validD & regWriteD;
      writeM    <= validE & regWriteE;
      writeW    <= writeM;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (instrValid) instrD <= instr;
    opcodeE    <= opcodeD;
    useImmE    <= useImmD;
    rnE        <= rnD;
    rmE        <= rmD;
    rdE        <= rdD;
    immE       <= immD;
    shamtE     <= shamtD;
    shiftTypeE <= shiftTypeD;
    rd1E       <= rd1D;
    rd2E       <= rd2D;
    resultM    <= resultE;
    rdM        <= rdE;
    resultW    <= resultM;
    rdW        <= rdM;
  end

  instrDecoder decoder (
    .instr(instrD), .opcode(opcodeD), .setFlags(setFlagsD), .useImm(useImmD),
    .regWrite(regWriteD), .rn(rnD), .rm(rmD), .rd(rdD), .imm(immD),
    .shamt(shamtD), .shiftType(shiftTypeD)
  );

  // Written from W, read in D
  regFile regs (
    .clk(clk), .rstN(rstN), .ra1(rnD), .ra2(rmD),
    .we(writeW), .wa(rdW), .wd(resultW), .rd1(rd1D), .rd2(rd2D)
  );

  forwardUnit fwd (
    .rnE(rnE), .rmE(rmE), .rdM(rdM), .writeM(writeM),
    .rdW(rdW), .writeW(writeW), .fwdA(fwdA), .fwdB(fwdB)
  );

  assign srcA  = fwdMux(fwdA, rd1E, resultW, resultM);
  assign srcRm = fwdMux(fwdB, rd2E, resultW, resultM);  // Forwarded before the shift

  barrelShifter shifter (
    .value(srcRm), .shamt(shamtE), .shiftType(shiftTypeE), .shifted(shiftedRm)
  );

  assign srcB = useImmE ? immE : shiftedRm;

  alu aluUnit (
    .a(srcA), .b(srcB), .opcode(opcodeE),
    .carryIn(flags[isaPkg::flagC]), .overflowIn(flags[isaPkg::flagV]),
    .result(resultE), .newFlags(newFlags)
  );

  // Flags load as the instruction leaves E, next E sees them
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      flags <= '0;
    else if (setFlagsE)
      flags <= newFlags;
  end

  assign wbValid = writeW;
  assign wbReg   = rdW;
  assign wbData  = resultW;

endmodule

//--- testbench/pipeCore_assert.sv
`timescale 1ns/1ps

`include "core_params.svh"

module coreChecks (
  input logic                         clk,
  input logic                         rstN,
  input logic                         instrValid,
  input logic                         wbValid,
  input logic [3:0]                   wbReg,
  input logic [`CORE_DATA_WIDTH-1:0]  wbData,
  input logic [`CORE_FLAGS_WIDTH-1:0] flags
);

  int failCount = 0;  // Assertion failures so far

  wbValidKnown: assert property (@(posedge clk) disable iff (!rstN)
    !$isunknown(wbValid))
    else begin
      failCount++;
      $error("wbValid is unknown");
    end

  // Issue at edge k shows up on W after edge k+3, sampled here at k+4
  wbFromIssue: assert property (@(posedge clk) disable iff (!rstN)
    wbValid |-> $past(instrValid, 4))
    else begin
      failCount++;
      $error("Writeback without an instruction four samples back");
    end

  wbPayloadKnown: assert property (@(posedge clk) disable iff (!rstN)
    wbValid |-> !$isunknown({wbReg, wbData}))
    else begin
      failCount++;
      $error("Writeback register or data unknown");
    end

  flagsKnown: assert property (@(posedge clk) disable iff (!rstN)
    !$isunknown(flags))
    else begin
      failCount++;
      $error("Flags unknown");
    end

endmodule

bind pipeCore coreChecks assertChk (
  .clk(clk), .rstN(rstN), .instrValid(instrValid), .wbValid(wbValid),
  .wbReg(wbReg), .wbData(wbData), .flags(flags)
);

//--- testbench/pipeCore_tb.sv
`timescale 1ns/1ps

module pipeCore_tb;

  localparam int randCount = 40;
  localparam int clkPeriod = 100;

  logic        clk;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instr;
  logic        wbValid;
  logic [3:0]  wbReg;
  logic [31:0] wbData;
  logic [3:0]  flags;

  int errors = 0;
  int checks = 0;

  // Directed table, one slot per entry
  logic        tabValid [$];
  logic [31:0] tabInstr [$];
  logic        tabWrite [$];
  logic [3:0]  tabReg [$];
  logic [31:0] tabData [$];
  logic [3:0]  tabFlags [$];

  logic [40:0] pending [$];  // {write, reg, data, flags} per issued slot

  logic [31:0] modelRegs [16];
  logic [3:0]  modelFlags;
  logic [31:0] lfsr = 32'ha2fc;

  pipeCore dut (
    .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .flags(flags)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] immInstr(input logic [3:0] op, input logic s,
                                           input logic [3:0] rn, input logic [3:0] rd,
                                           input logic [11:0] imm);
    return {6'b0, 1'b1, op, s, rn, rd, imm};
  endfunction

  function automatic logic [31:0] regInstr(input logic [3:0] op, input logic s,
                                           input logic [3:0] rn, input logic [3:0] rd,
                                           input logic [3:0] rm, input logic [1:0] sh,
                                           input logic [4:0] amt);
    return {6'b0, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
  endfunction

  task automatic addEntry(input logic v, input logic [31:0] ins, input logic w,
                          input logic [3:0] r, input logic [31:0] d, input logic [3:0] f);
    tabValid.push_back(v);
    tabInstr.push_back(ins);
    tabWrite.push_back(w);
    tabReg.push_back(r);
    tabData.push_back(d);
    tabFlags.push_back(f);
  endtask

  // Sequential reference, one instruction in program order
  task automatic modelStep(input logic [31:0] ins, output logic w, output logic [3:0] r,
                           output logic [31:0] d);
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [4:0]  amt;
    logic [32:0] wide;
    logic        known;
    logic        arith;
    logic        setF;
    op = ins[24:21];
    a = modelRegs[ins[19:16]];
    v = modelRegs[ins[3:0]];
    amt = ins[11:7];
    case (ins[6:5])
      2'd0: b = v << amt;
      2'd1: b = v >> amt;
      2'd2: b = $signed(v) >>> amt;
      default: b = (amt == 0) ? v : ((v >> amt) | (v << (32 - amt)));
    endcase
    if (ins[25])
      b = {20'b0, ins[11:0]};
    known = 1'b1;
    arith = 1'b0;
    wide = '0;
    case (op)
      4'd0: d = a & b;
      4'd1: d = a ^ b;
      4'd12: d = a | b;
      4'd13: d = b;
      4'd2, 4'd10: begin
        wide = {1'b0, a} - {1'b0, b};
        d = wide[31:0];
        arith = 1'b1;
      end
      4'd4, 4'd5: begin
        wide = {1'b0, a} + {1'b0, b} + ((op == 4'd5) ? modelFlags[1] : 1'b0);
        d = wide[31:0];
        arith = 1'b1;
      end
      default: begin
        d = '0;
        known = 1'b0;
      end
    endcase
    w = known && (op != 4'd10);
    r = ins[15:12];
    setF = known && (ins[20] || op == 4'd10);
    if (setF) begin
      modelFlags[3] = d[31];
      modelFlags[2] = (d == 0);
      if (arith) begin
        if (op == 4'd2 || op == 4'd10) begin
          modelFlags[1] = ~wide[32];  // No borrow
          modelFlags[0] = (a[31] != b[31]) && (d[31] != a[31]);
        end else begin
          modelFlags[1] = wide[32];
          modelFlags[0] = (a[31] == b[31]) && (d[31] != a[31]);
        end
      end
    end
    if (w)
      modelRegs[r] = d;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  // Runs at the falling edge before the next slot is driven
  task automatic checkOutputs();
    logic [40:0] e;
    if (pending.size() == 4) begin
      e = pending.pop_front();
      if (wbValid !== e[40]) begin
        errors++;
        checks++;
        if (e[40])
          $display("Writeback to register %0d is missing at %0t", e[39:36], $time);
        else
          $display("Writeback appeared where none was expected at %0t", $time);
      end else if (e[40]) begin
        checkValue("wbReg", wbReg, e[39:36]);
        checkValue("wbData", wbData, e[35:4]);
      end
    end else if (wbValid !== 1'b0) begin
      errors++;
      checks++;
      $display("Writeback appeared before any instruction could reach W at %0t", $time);
    end
    if (pending.size() == 3)
      checkValue("flags", flags, pending[0][3:0]);
  endtask

  task automatic issueSlot(input logic v, input logic [31:0] ins, input logic w,
                           input logic [3:0] r, input logic [31:0] d, input logic [3:0] f);
    @(negedge clk);
    checkOutputs();
    instrValid = v;
    instr = ins;
    pending.push_back({w & v, r, d, f});
  endtask

  initial begin
    #((16 + 23 + randCount + 20) * clkPeriod);
    $display("Watchdog expired before the test sequence finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic        w;
    logic [3:0]  r;
    logic [31:0] d;
    logic [31:0] ins;
    logic [31:0] rnd;  // {I, op index, S, Rn, Rd, low 12 bits}
    logic [3:0]  ops [8];
    clk = 1'b0;
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    modelFlags = '0;
    for (int i = 0; i < 16; i++) modelRegs[i] = '0;
    ops = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd10, 4'd12, 4'd13};

    for (int i = 0; i < 16; i++)
      addEntry(1, regInstr(13, 0, 0, i, i, 0, 0), 1, i, 0, 4'h0);  // Reset values
    addEntry(1, immInstr(13, 0, 0, 1, 12'h0ff), 1, 1, 32'h0ff, 4'h0);
    addEntry(1, immInstr(13, 0, 0, 2, 12'h801), 1, 2, 32'h801, 4'h0);
    addEntry(1, regInstr(4, 0, 1, 3, 2, 0, 0), 1, 3, 32'h900, 4'h0);   // M and W bypass
    addEntry(1, immInstr(2, 0, 3, 4, 12'h001), 1, 4, 32'h8ff, 4'h0);
    addEntry(1, regInstr(13, 0, 0, 5, 1, 0, 28), 1, 5, 32'hf0000000, 4'h0);
    addEntry(1, regInstr(13, 0, 0, 6, 5, 2, 4), 1, 6, 32'hff000000, 4'h0);
    addEntry(1, regInstr(13, 0, 0, 7, 5, 1, 4), 1, 7, 32'h0f000000, 4'h0);
    addEntry(1, regInstr(13, 0, 0, 8, 5, 3, 30), 1, 8, 32'hc0000003, 4'h0);  // Distance 3
    addEntry(1, regInstr(1, 0, 8, 9, 7, 0, 0), 1, 9, 32'hcf000003, 4'h0);
    addEntry(1, immInstr(12, 0, 2, 10, 12'h0f0), 1, 10, 32'h8f1, 4'h0);
    addEntry(1, regInstr(0, 0, 10, 11, 1, 0, 0), 1, 11, 32'hf1, 4'h0);
    addEntry(0, regInstr(4, 0, 0, 11, 0, 0, 0), 0, 0, 0, 4'h0);           // Bubble
    addEntry(1, regInstr(4, 0, 11, 4, 4, 0, 0), 1, 4, 32'h9f0, 4'h0);
    addEntry(1, regInstr(4, 1, 5, 12, 5, 0, 0), 1, 12, 32'he0000000, 4'ha);
    addEntry(1, immInstr(5, 0, 1, 13, 12'h000), 1, 13, 32'h100, 4'ha);     // Uses new C
    addEntry(1, immInstr(10, 0, 1, 0, 12'h0ff), 0, 0, 0, 4'h6);
    addEntry(1, immInstr(3, 1, 1, 0, 12'h0ff), 0, 0, 0, 4'h6);             // Unknown opcode
    addEntry(1, regInstr(2, 1, 2, 14, 3, 0, 0), 1, 14, 32'hffffff01, 4'h8);
    addEntry(1, immInstr(5, 1, 14, 0, 12'h001), 1, 0, 32'hffffff02, 4'h8);
    addEntry(1, immInstr(4, 1, 0, 15, 12'h0fe), 1, 15, 32'h0, 4'h6);
    addEntry(1, immInstr(5, 0, 15, 1, 12'h000), 1, 1, 32'h1, 4'h6);
    addEntry(1, immInstr(0, 1, 1, 2, 12'h000), 1, 2, 32'h0, 4'h6);
    addEntry(1, regInstr(13, 1, 0, 3, 5, 0, 0), 1, 3, 32'hf0000000, 4'ha);

    repeat (5) @(negedge clk);
    rstN = 1'b1;

    for (int i = 0; i < tabInstr.size(); i++) begin
      if (tabValid[i])
        modelStep(tabInstr[i], w, r, d);  // Keeps the model in step for the random part
      issueSlot(tabValid[i], tabInstr[i], tabWrite[i], tabReg[i], tabData[i], tabFlags[i]);
    end

    for (int i = 0; i < randCount; i++) begin
      if (lfsrBits(2) == 0) begin
        issueSlot(0, '0, 0, 0, 0, modelFlags);
      end else begin
        rnd = lfsrBits(25);
        ins = {6'b0, rnd[24], ops[rnd[23:21]], rnd[20:0]};
        modelStep(ins, w, r, d);
        issueSlot(1, ins, w, r, d, modelFlags);
      end
    end

    repeat (4) issueSlot(0, '0, 0, 0, 0, modelFlags);  // Drain the pipeline
    checkValue("final flags", flags, modelFlags);

    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut.assertChk.failCount);
    if (errors == 0 && dut.assertChk.failCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/barrelShifter.sv
verilog/alu.sv
verilog/forwardUnit.sv
verilog/pipeCore.sv
testbench/pipeCore_assert.sv
testbench/pipeCore_tb.sv

//--- Bender.yml
package:
  name: pipe_core

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/isaPkg.sv
      - verilog/pipePkg.sv
      - verilog/instrDecoder.sv
      - verilog/regFile.sv
      - verilog/barrelShifter.sv
      - verilog/alu.sv
      - verilog/forwardUnit.sv
      - verilog/pipeCore.sv
  - target: test
    files:
      - testbench/pipeCore_assert.sv
      - testbench/pipeCore_tb.sv
